// File: memoryController.f
+incdir+hw
hw/memcPkg.sv
hw/busPkg.sv
hw/transferFifo.sv
hw/memoryInterface.sv
hw/cacheInterface.sv
hw/memoryController.sv
testbench/memoryModels.sv
testbench/memoryController_assertions.sv
testbench/memoryControllerChecker.sv
testbench/memoryControllerTb.sv

// File: Bender.yml
package:
  name: memory_controller

sources:
  - include_dirs:
      - hw
    files:
      - hw/memcPkg.sv
      - hw/busPkg.sv
      - hw/transferFifo.sv
      - hw/memoryInterface.sv
      - hw/cacheInterface.sv
      - hw/memoryController.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/memoryModels.sv
      - testbench/memoryController_assertions.sv
      - testbench/memoryControllerChecker.sv
      - testbench/memoryControllerTb.sv

// File: testbench/memoryControllerTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "memoryController_params.svh"

module memoryControllerTb;

    localparam int NumCmds = 9;
    localparam int Words = 1 << `MEMC_SRAM_AW;

    logic clk;
    logic rst;
    logic extStall;
    memcPkg::memcCtrl ctrl;
    memcPkg::memcStat stat;
    busPkg::sramReq cacheReq [`MEMC_NUM_CACHES];
    memcPkg::dataWord cacheData [`MEMC_NUM_CACHES];
    busPkg::extBusOut extOut;
    memcPkg::dataWord extIn;
    logic [31:0] lfsrState;

    memoryController UUT (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl),
        .stat(stat),
        .cacheReq(cacheReq),
        .cacheData(cacheData),
        .extOut(extOut),
        .extStall(extStall),
        .extIn(extIn)
    );

    extMemModel extMem (.clk(clk), .rst(rst), .bus(extOut), .stall(extStall), .busIn(extIn));
    cacheSramModel cache0 (.clk(clk), .sram(cacheReq[0]), .rdData(cacheData[0]));
    cacheSramModel cache1 (.clk(clk), .sram(cacheReq[1]), .rdData(cacheData[1]));

    memoryControllerChecker scoreboard (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl),
        .stat(stat),
        .extOut(extOut),
        .extStall(extStall),
        .cacheReq(cacheReq)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic memcPkg::memcCtrl makeCmd(input memcPkg::memcCmd cmd, input int rq,
                                                 input int ext, input int sram, input int id,
                                                 input logic [31:0] data);
        memcPkg::memcCtrl c;
        c.cmd = cmd;
        c.rqId = rq[`MEMC_RQID_W-1:0];
        c.extAddr = ext[`MEMC_EXT_AW-1:0];
        c.sramAddr = sram[`MEMC_SRAM_AW-1:0];
        c.cacheId = id[0];
        c.data = data;
        return c;
    endfunction

    // Optionally fires a second command a few cycles in, while busy is high
    task automatic runCommand(input memcPkg::memcCtrl c, input logic sendExtra,
                              input memcPkg::memcCtrl extra);
        ctrl = c;
        @(posedge clk);
        #2;
        ctrl.cmd = memcPkg::none;
        if (sendExtra) begin
            repeat (4) @(posedge clk);
            #2;
            ctrl = extra;
            @(posedge clk);
            #2;
            ctrl.cmd = memcPkg::none;
        end
        while (stat.busy) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(NumCmds * 200 * 40);
        $display("watchdog timeout: the commands did not finish in the expected time");
        $display("FAIL: see errors above");
        $finish;
    end

    // Random stall, high about a quarter of the cycles
    initial begin
        forever begin
            @(posedge clk);
            #2;
            extStall = (takeBits(1) & takeBits(1)) != '0;
        end
    end

    initial begin
        memcPkg::memcCtrl idleCmd;
        logic [31:0] w;
        lfsrState = 32'd70438;
        rst = 1'b1;
        extStall = 1'b0;
        ctrl = '0;
        idleCmd = '0;
        for (int i = 0; i < Words; i++) begin
            w = takeBits(32);
            extMem.mem[i] = w;
            scoreboard.extShadow[i] = w;
            w = takeBits(32);
            cache0.mem[i] = w;
            scoreboard.cacheShadow[0][i] = w;
            w = takeBits(32);
            cache1.mem[i] = w;
            scoreboard.cacheShadow[1][i] = w;
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;

        runCommand(makeCmd(memcPkg::writeSingle, 1, 100, 0, 0, 32'hA5A5_1234), 1'b0, idleCmd);
        runCommand(makeCmd(memcPkg::readSingle, 2, 100, 0, 0, '0), 1'b0, idleCmd);
        runCommand(makeCmd(memcPkg::copyExtToCache, 3, 200, 64, 1, '0), 1'b0, idleCmd);
        runCommand(makeCmd(memcPkg::copyCacheToExt, 4, 400, 64, 1, '0), 1'b0, idleCmd);
        runCommand(makeCmd(memcPkg::copyCacheToExt, 5, 600, 64, 0, '0), 1'b0, idleCmd);
        // The read sent during the copy must be dropped
        runCommand(makeCmd(memcPkg::copyExtToCache, 6, 400, 300, 0, '0), 1'b1,
                   makeCmd(memcPkg::readSingle, 7, 100, 0, 0, '0));
        runCommand(makeCmd(memcPkg::copyCacheToExt, 8, 800, 300, 0, '0), 1'b0, idleCmd);
        runCommand(makeCmd(memcPkg::readSingle, 9, 815, 0, 0, '0), 1'b0, idleCmd);
        runCommand(makeCmd(memcPkg::readSingle, 10, 231, 0, 0, '0), 1'b0, idleCmd);

        repeat (2) @(posedge clk);
        $display("checks done: %0d value errors, %0d protocol errors, %0d assertion failures",
                 scoreboard.valueErrors, scoreboard.protocolErrors,
                 UUT.handshakeChecks.failCount);
        if (scoreboard.valueErrors == 0 && scoreboard.protocolErrors == 0
                && UUT.handshakeChecks.failCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/memoryControllerChecker.sv
`timescale 1ns/1ps
`default_nettype none
`include "memoryController_params.svh"

module memoryControllerChecker (
    input  logic clk,
    input  logic rst,
    input  memcPkg::memcCtrl ctrl,
    input  memcPkg::memcStat stat,
    input  busPkg::extBusOut extOut,
    input  logic extStall,
    input  busPkg::sramReq cacheReq [`MEMC_NUM_CACHES]
);

    localparam int Words = 1 << `MEMC_SRAM_AW;

    memcPkg::dataWord extShadow [Words];
    memcPkg::dataWord cacheShadow [`MEMC_NUM_CACHES][Words];
    memcPkg::dataWord expWrites [$];
    memcPkg::dataWord expResults [$];
    busPkg::extHeader expHdr;
    busPkg::extHeader gotHdr;
    logic headerNext;
    logic [`MEMC_RQID_W-1:0] expRqId;
    int expProgress;
    logic prevBusy;
    logic prevRst;
    int valueErrors;
    int protocolErrors;

    // Applies one accepted command to the shadows and queues what the bus must show
    function automatic void applyCommand(input memcPkg::memcCtrl c);
        int e;
        int s;
        memcPkg::dataWord w;
        e = int'(c.extAddr[`MEMC_SRAM_AW-1:0]);
        s = int'(c.sramAddr);
        expHdr.addr = c.extAddr;
        expHdr.burst = (c.cmd == memcPkg::copyExtToCache) || (c.cmd == memcPkg::copyCacheToExt);
        expHdr.write = (c.cmd == memcPkg::writeSingle) || (c.cmd == memcPkg::copyCacheToExt);
        expProgress = expHdr.burst ? `MEMC_BURST_LEN : 1;
        case (c.cmd)
            memcPkg::readSingle: expResults.push_back(extShadow[e]);
            memcPkg::writeSingle: begin
                extShadow[e] = c.data;
                expWrites.push_back(c.data);
            end
            memcPkg::copyExtToCache: begin
                for (int i = 0; i < `MEMC_BURST_LEN; i++) begin
                    cacheShadow[c.cacheId][(s + i) % Words] = extShadow[(e + i) % Words];
                end
            end
            default: begin
                for (int i = 0; i < `MEMC_BURST_LEN; i++) begin
                    w = cacheShadow[c.cacheId][(s + i) % Words];
                    extShadow[(e + i) % Words] = w;
                    expWrites.push_back(w);
                end
            end
        endcase
    endfunction

    initial begin
        valueErrors = 0;
        protocolErrors = 0;
        headerNext = 1'b0;
        prevBusy = 1'b0;
        prevRst = 1'b0;
    end

    assign gotHdr = extOut.bus;

    always @(posedge clk) begin
        prevRst <= rst;
        prevBusy <= stat.busy;
        if (prevRst && !rst) begin
            if (stat.busy || stat.resultValid || extOut.en || extOut.oen) begin
                $display("reset check failed: busy, resultValid, en or oen is high");
                protocolErrors++;
            end
            for (int i = 0; i < `MEMC_NUM_CACHES; i++) begin
                if (!cacheReq[i].ce || !cacheReq[i].we) begin
                    $display("reset check failed: cache %0d strobes are not high", i);
                    protocolErrors++;
                end
            end
        end
        if (!rst) begin
            // The next command can be accepted on the same edge that closes the last one
            if (prevBusy && !stat.busy) begin
                if (expWrites.size() != 0 || expResults.size() != 0 || headerNext) begin
                    $display("a command finished with beats or results still missing");
                    protocolErrors++;
                    expWrites.delete();
                    expResults.delete();
                    headerNext = 1'b0;
                end
                if (stat.progress != `MEMC_LEN_W'(expProgress) || stat.rqId != expRqId) begin
                    $display("error at %0t ns: progress %0d rqId %0d, expected %0d and %0d",
                             $time, stat.progress, stat.rqId, expProgress, expRqId);
                    valueErrors++;
                end
            end
            if (!stat.busy && ctrl.cmd != memcPkg::none) begin
                applyCommand(ctrl);
                expRqId = ctrl.rqId;
                headerNext = 1'b1;
            end
            if (extOut.en && !extStall) begin
                if (headerNext) begin
                    headerNext = 1'b0;
                    if (gotHdr !== expHdr) begin
                        $display("error at %0t ns: header %h, expected %h",
                                 $time, gotHdr, expHdr);
                        valueErrors++;
                    end
                end else if (extOut.oen) begin
                    if (expWrites.size() == 0) begin
                        $display("an external write beat came that no command asked for");
                        protocolErrors++;
                    end else if (extOut.bus !== expWrites[0]) begin
                        $display("error at %0t ns: write beat %h, expected %h",
                                 $time, extOut.bus, expWrites.pop_front());
                        valueErrors++;
                    end else begin
                        void'(expWrites.pop_front());
                    end
                end
            end
            if (stat.resultValid) begin
                if (expResults.size() == 0) begin
                    $display("resultValid pulsed with no single read outstanding");
                    protocolErrors++;
                end else if (stat.result !== expResults[0]) begin
                    $display("error at %0t ns: result %h, expected %h",
                             $time, stat.result, expResults.pop_front());
                    valueErrors++;
                end else begin
                    void'(expResults.pop_front());
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/memoryController_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module memoryControllerAssertions (
    input  logic clk,
    input  logic rst,
    input  busPkg::extBusOut extOut,
    input  logic extStall,
    input  memcPkg::memcStat stat
);

    int failCount = 0;

    // A stalled beat keeps en and the bus word
    assert property (@(posedge clk) disable iff (rst)
        extOut.en && extStall |=> extOut.en && $stable(extOut.bus))
        else begin
            $error("en or bus changed under stall");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (rst)
        stat.resultValid |=> !stat.resultValid)
        else begin
            $error("resultValid high for two cycles");
            failCount++;
        end

    assert property (@(posedge clk) rst |=> !stat.busy)
        else begin
            $error("busy high after reset");
            failCount++;
        end

endmodule

bind memoryController memoryControllerAssertions handshakeChecks (
    .clk(clk),
    .rst(rst),
    .extOut(extOut),
    .extStall(extStall),
    .stat(stat)
);

`default_nettype wire

// File: testbench/memoryModels.sv
`timescale 1ns/1ps
`default_nettype none
`include "memoryController_params.svh"

module extMemModel (
    input  logic clk,
    input  logic rst,
    input  busPkg::extBusOut bus,
    input  logic stall,
    output memcPkg::dataWord busIn
);

    localparam int Words = 1 << `MEMC_SRAM_AW;

    memcPkg::dataWord mem [Words];
    busPkg::extHeader hdr;
    logic [`MEMC_SRAM_AW-1:0] curAddr;    // Only the low address bits are modeled
    int remaining;
    logic isWrite;

    assign hdr = bus.bus;
    assign busIn = mem[curAddr];

    always @(posedge clk) begin
        if (rst) begin
            remaining <= 0;
            curAddr <= '0;
            isWrite <= 1'b0;
        end else if (bus.en && !stall) begin
            if (remaining == 0) begin
                curAddr <= hdr.addr[`MEMC_SRAM_AW-1:0];
                isWrite <= hdr.write;
                remaining <= hdr.burst ? `MEMC_BURST_LEN : 1;
            end else begin
                if (isWrite) begin
                    mem[curAddr] <= bus.bus;
                end
                curAddr <= curAddr + 1'b1;
                remaining <= remaining - 1;
            end
        end
    end

endmodule

module cacheSramModel (
    input  logic clk,
    input  busPkg::sramReq sram,
    output memcPkg::dataWord rdData
);

    memcPkg::dataWord mem [1 << `MEMC_SRAM_AW];

    always @(posedge clk) begin
        if (!sram.ce) begin
            if (!sram.we) begin
                mem[sram.addr] <= sram.data;
            end else begin
                rdData <= mem[sram.addr];   // One cycle read latency
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/memoryController.sv
`timescale 1ns/1ps
`default_nettype none
`include "memoryController_params.svh"

module memoryController (
    input  logic clk,
    input  logic rst,

    input  memcPkg::memcCtrl ctrl,
    output memcPkg::memcStat stat,

    output busPkg::sramReq cacheReq [`MEMC_NUM_CACHES],
    input  memcPkg::dataWord cacheData [`MEMC_NUM_CACHES],

    output busPkg::extBusOut extOut,
    input  logic extStall,
    input  memcPkg::dataWord extIn
);

    localparam int CntW = $clog2(`MEMC_FIFO_DEPTH + 1);

    typedef enum logic {
        ctlIdle,
        ctlWait
    } ctlState;

    ctlState state;
    memcPkg::memcCmd cmdReg;
    logic accept;
    logic isCopy;
    logic toCache;
    logic toExt;
    busPkg::xferLen xferLength;
    memcPkg::dataWord singleData;
    logic singleValid;

    logic memBusy;
    logic memBeatDone;
    logic memWrTake;
    logic memWrAvail;
    logic memRdSpace;
    memcPkg::dataWord memRdData;
    memcPkg::dataWord memWrData;

    logic cacheBusy;
    logic cacheInTake;
    logic cachePush;
    memcPkg::dataWord cacheOutData;
    memcPkg::dataWord sramData;
    memcPkg::cacheId cacheSel;
    busPkg::sramReq cacheSram;

    logic fifoPush;
    logic fifoPop;
    logic fifoFull;
    logic fifoEmpty;
    memcPkg::dataWord fifoPushData;
    memcPkg::dataWord fifoPopData;
    logic [CntW-1:0] fifoCount;
    logic [CntW-1:0] freeSlots;

    assign accept = (state == ctlIdle) && (ctrl.cmd != memcPkg::none);
    assign isCopy = (ctrl.cmd == memcPkg::copyExtToCache) || (ctrl.cmd == memcPkg::copyCacheToExt);
    assign xferLength = isCopy ? busPkg::xferLen'(`MEMC_BURST_LEN) : busPkg::xferLen'(1);

    // Routing follows the command latched at acceptance
    assign toCache = cmdReg == memcPkg::copyExtToCache;
    assign toExt = cmdReg == memcPkg::copyCacheToExt;
    assign fifoPush = toCache ? memBeatDone : cachePush;
    assign fifoPushData = toCache ? memRdData : cacheOutData;
    assign fifoPop = toExt ? memWrTake : cacheInTake;
    assign freeSlots = CntW'(`MEMC_FIFO_DEPTH) - fifoCount;

    // Single writes bypass the FIFO, single reads never wait for space
    assign memWrAvail = (cmdReg == memcPkg::writeSingle) ? singleValid : !fifoEmpty;
    assign memWrData = (cmdReg == memcPkg::writeSingle) ? singleData : fifoPopData;
    assign memRdSpace = (cmdReg == memcPkg::readSingle) || !fifoFull;

    memoryInterface memIf (
        .clk(clk),
        .rst(rst),
        .start(accept),
        .write((ctrl.cmd == memcPkg::writeSingle) || (ctrl.cmd == memcPkg::copyCacheToExt)),
        .len(xferLength),
        .addr(ctrl.extAddr),
        .busy(memBusy),
        .beatDone(memBeatDone),
        .rdData(memRdData),
        .wrData(memWrData),
        .wrAvail(memWrAvail),
        .rdSpace(memRdSpace),
        .wrTake(memWrTake),
        .bus(extOut),
        .stall(extStall),
        .busIn(extIn)
    );

    cacheInterface cacheIf (
        .clk(clk),
        .rst(rst),
        .start(accept && isCopy),
        .write(ctrl.cmd == memcPkg::copyExtToCache),
        .len(xferLength),
        .base(ctrl.sramAddr),
        .sel(ctrl.cacheId),
        .busy(cacheBusy),
        .inAvail(!fifoEmpty),
        .inData(fifoPopData),
        .inTake(cacheInTake),
        .outSpace(freeSlots),
        .outPush(cachePush),
        .outData(cacheOutData),
        .selOut(cacheSel),
        .sram(cacheSram),
        .sramData(sramData)
    );

    transferFifo #(
        .DEPTH(`MEMC_FIFO_DEPTH)
    ) xferFifo (
        .clk(clk),
        .rst(rst),
        .push(fifoPush),
        .pushData(fifoPushData),
        .pop(fifoPop),
        .popData(fifoPopData),
        .full(fifoFull),
        .empty(fifoEmpty),
        .count(fifoCount)
    );

    // Unselected caches keep both strobes high
    always_comb begin
        for (int i = 0; i < `MEMC_NUM_CACHES; i++) begin
            cacheReq[i] = cacheSram;
            if (memcPkg::cacheId'(i) != cacheSel) begin
                cacheReq[i].ce = 1'b1;
                cacheReq[i].we = 1'b1;
            end
        end
    end

    assign sramData = cacheData[cacheSel];

    always_ff @(posedge clk) begin
        if (accept) begin
            stat.rqId <= ctrl.rqId;
            singleData <= ctrl.data;
        end
        if (memBeatDone && cmdReg == memcPkg::readSingle) begin
            stat.result <= memRdData;
        end

        if (rst) begin
            state <= ctlIdle;
            cmdReg <= memcPkg::none;
            singleValid <= 1'b0;
            stat.busy <= 1'b0;
            stat.progress <= '0;
            stat.resultValid <= 1'b0;
        end else begin
            stat.resultValid <= memBeatDone && (cmdReg == memcPkg::readSingle);
            if (memBeatDone) begin
                stat.progress <= stat.progress + 1'b1;
            end
            if (memWrTake && cmdReg == memcPkg::writeSingle) begin
                singleValid <= 1'b0;
            end
            case (state)
                ctlIdle: begin
                    if (accept) begin
                        state <= ctlWait;
                        cmdReg <= ctrl.cmd;
                        singleValid <= ctrl.cmd == memcPkg::writeSingle;
                        stat.busy <= 1'b1;
                        stat.progress <= '0;
                    end
                end
                ctlWait: begin
                    if (!memBusy && !cacheBusy) begin
                        state <= ctlIdle;   // Both sides drained
                        stat.busy <= 1'b0;
                    end
                end
                default: state <= ctlIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/cacheInterface.sv
`timescale 1ns/1ps
`default_nettype none
`include "memoryController_params.svh"

module cacheInterface (
    input  logic clk,
    input  logic rst,

    input  logic start,
    input  logic write,
    input  busPkg::xferLen len,
    input  memcPkg::sramAddr base,
    input  memcPkg::cacheId sel,
    output logic busy,

    input  logic inAvail,
    input  memcPkg::dataWord inData,
    output logic inTake,
    input  logic [$clog2(`MEMC_FIFO_DEPTH + 1)-1:0] outSpace,
    output logic outPush,
    output memcPkg::dataWord outData,

    output memcPkg::cacheId selOut,
    output busPkg::sramReq sram,
    input  memcPkg::dataWord sramData
);

    localparam int SpaceW = $clog2(`MEMC_FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        idle,
        xfer,
        done
    } ciState;

    ciState state;
    busPkg::xferLen remaining;
    memcPkg::sramAddr addrReg;
    logic isWrite;
    logic readPending;
    logic [SpaceW-1:0] inFlight;
    logic step;

    assign busy = state != idle;
    assign inFlight = {{(SpaceW - 1){1'b0}}, readPending};

    // A read still on its way back already owns one FIFO slot
    always_comb begin
        step = 1'b0;
        if (state == xfer) begin
            step = isWrite ? inAvail : (outSpace > inFlight);
        end
    end

    assign inTake = step && isWrite;
    assign outPush = readPending;     // SRAM word arrives one cycle after the read
    assign outData = sramData;

    always_comb begin
        sram.ce = !step;
        sram.we = !(step && isWrite);
        sram.addr = addrReg;
        sram.data = inData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            remaining <= '0;
            readPending <= 1'b0;
            selOut <= '0;
        end else begin
            readPending <= step && !isWrite;
            case (state)
                idle: begin
                    if (start) begin
                        state <= xfer;
                        remaining <= len;
                        selOut <= sel;
                    end
                end
                xfer: begin
                    if (step) begin
                        remaining <= remaining - 1'b1;
                        if (remaining == busPkg::xferLen'(1)) begin
                            state <= done;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            addrReg <= base;
            isWrite <= write;
        end else if (step) begin
            addrReg <= addrReg + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/memoryInterface.sv
`timescale 1ns/1ps
`default_nettype none

module memoryInterface (
    input  logic clk,
    input  logic rst,

    input  logic start,
    input  logic write,
    input  busPkg::xferLen len,
    input  memcPkg::extAddr addr,
    output logic busy,

    output logic beatDone,
    output memcPkg::dataWord rdData,
    input  memcPkg::dataWord wrData,
    input  logic wrAvail,
    input  logic rdSpace,
    output logic wrTake,

    output busPkg::extBusOut bus,
    input  logic stall,
    input  memcPkg::dataWord busIn
);

    typedef enum logic [1:0] {
        idle,
        header,
        data,
        done
    } miState;

    miState state;
    busPkg::extHeader hdr;
    busPkg::xferLen remaining;
    logic isWrite;

    assign busy = state != idle;
    assign beatDone = (state == data) && bus.en && !stall;
    assign wrTake = beatDone && isWrite;
    assign rdData = busIn;            // Taken by the FIFO or the status on beatDone

    // A stalled beat keeps its word, since nothing is taken until it completes
    always_comb begin
        bus = '0;
        case (state)
            header: begin
                bus.en = 1'b1;
                bus.oen = 1'b1;
                bus.bus = memcPkg::dataWord'(hdr);
            end
            data: begin
                if (isWrite) begin
                    bus.en = wrAvail;
                    bus.oen = 1'b1;
                    bus.bus = wrData;
                end else begin
                    bus.en = rdSpace;   // Slave drives busIn, oen stays low
                end
            end
            default: bus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            remaining <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= header;
                        remaining <= len;
                    end
                end
                header: begin
                    if (!stall) begin
                        state <= data;
                    end
                end
                data: begin
                    if (beatDone) begin
                        remaining <= remaining - 1'b1;
                        if (remaining == busPkg::xferLen'(1)) begin
                            state <= done;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            hdr.addr <= addr;
            hdr.burst <= len > busPkg::xferLen'(1);
            hdr.write <= write;
            isWrite <= write;
        end
    end

endmodule

`default_nettype wire

// File: hw/transferFifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "memoryController_params.svh"

module transferFifo #(
    parameter int DEPTH = `MEMC_FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  memcPkg::dataWord pushData,
    input  logic pop,
    output memcPkg::dataWord popData,
    output logic full,
    output logic empty,
    output logic [$clog2(DEPTH + 1)-1:0] count
);

    localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CntW = $clog2(DEPTH + 1);

    memcPkg::dataWord mem [DEPTH];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic doPush;
    logic doPop;

    assign full = count == CntW'(DEPTH);
    assign empty = count == '0;
    assign doPush = push && !full;
    assign doPop = pop && !empty;     // Pop on an empty buffer does nothing
    assign popData = mem[rdPtr];      // Head word is visible before the pop

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PtrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CntW'(doPush) - CntW'(doPop);
        end
    end

endmodule

`default_nettype wire

// File: hw/busPkg.sv
`default_nettype none
`include "memoryController_params.svh"

package busPkg;

    typedef logic [`MEMC_LEN_W-1:0] xferLen;

    // First beat of every transfer, exactly one bus word wide
    typedef struct packed {
        memcPkg::extAddr addr;
        logic burst;
        logic write;
    } extHeader;

    typedef struct packed {
        logic en;
        logic oen;                // High while the master drives the bus
        memcPkg::dataWord bus;
    } extBusOut;

    // Strobes are active low
    typedef struct packed {
        logic ce;
        logic we;
        memcPkg::sramAddr addr;
        memcPkg::dataWord data;
    } sramReq;

endpackage

`default_nettype wire

// File: hw/memcPkg.sv
`default_nettype none
`include "memoryController_params.svh"

package memcPkg;

    typedef logic [`MEMC_DATA_W-1:0] dataWord;
    typedef logic [`MEMC_EXT_AW-1:0] extAddr;
    typedef logic [`MEMC_SRAM_AW-1:0] sramAddr;
    typedef logic [$clog2(`MEMC_NUM_CACHES)-1:0] cacheId;
    typedef logic [`MEMC_RQID_W-1:0] rqId;

    typedef enum logic [2:0] {
        none,
        readSingle,
        writeSingle,
        copyExtToCache,
        copyCacheToExt
    } memcCmd;

    typedef struct packed {
        memcCmd cmd;
        logic [`MEMC_RQID_W-1:0] rqId;
        logic [`MEMC_EXT_AW-1:0] extAddr;
        logic [`MEMC_SRAM_AW-1:0] sramAddr;
        logic [$clog2(`MEMC_NUM_CACHES)-1:0] cacheId;
        dataWord data;            // Only used by writeSingle
    } memcCtrl;

    typedef struct packed {
        logic busy;
        logic [`MEMC_RQID_W-1:0] rqId;
        logic [`MEMC_LEN_W-1:0] progress;   // External data beats done so far
        dataWord result;
        logic resultValid;
    } memcStat;

endpackage

`default_nettype wire

// File: hw/memoryController_params.svh
`ifndef MEMORYCONTROLLER_PARAMS_SVH
`define MEMORYCONTROLLER_PARAMS_SVH

// Cache side, two SRAMs of 1024 words
`define MEMC_NUM_CACHES 2
`define MEMC_SRAM_AW 10

// External bus is word addressed
`define MEMC_DATA_W 32
`define MEMC_EXT_AW 30

`define MEMC_LEN_W 8
`define MEMC_RQID_W 6

// Words moved by one copy command
`define MEMC_BURST_LEN 32

`define MEMC_FIFO_DEPTH 4

`endif
